// ==== hdl/colorPriority.sv ====
`timescale 1ns/1ps

module colorPriority import compositorPkg::*;
(
    input  logic                clk,
    input  logic                arstN,
    input  regionFlags          region,
    input  logic                playerHit,
    input  logic [numRects-1:0] wallHits,
    input  logic [numRects-1:0] scrollHits,
    input  pixelColor_t         playerColor,
    output pixelColor_t         sel
);

    pixelColor_t scrollSel;
    pixelColor_t selNext;
    logic wallAny;
    logic scrollAny;

    assign wallAny = |wallHits;     // walls are always white
    assign scrollAny = |scrollHits;

    ////////////////////////////////////////
    // scroll objects, set major then slot
    ////////////////////////////////////////

    // walk from the highest index down so the lowest hit is written last
    always_comb
    begin
        scrollSel = colorBlack;
        for (int set = numSets - 1; set >= 0; set--)
        begin
            for (int slot = numSlots - 1; slot >= 0; slot--)
            begin
                if (scrollHits[set * numSlots + slot])
                begin
                    scrollSel = scrollColor[set][slot];
                end
            end
        end
    end

    ////////////////////////////////////////
    // layer priority
    ////////////////////////////////////////

    always_comb
    begin
        if (!region.inDisplay)
        begin
            selNext = colorBlack;       // blanking
        end
        else if (region.onBorder)
        begin
            selNext = colorWhite;
        end
        else if (playerHit)
        begin
            selNext = playerColor;      // player sits above everything else
        end
        else if (wallAny)
        begin
            selNext = colorWhite;
        end
        else if (scrollAny)
        begin
            selNext = scrollSel;
        end
        else
        begin
            // empty background
            selNext = colorBlack;
        end
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            sel <= colorBlack;
        end
        else
        begin
            sel <= selNext;     // stage 2 register
        end
    end

endmodule

// ==== hdl/compositorPkg.sv ====
package compositorPkg;

    ////////////////////////////////////////
    // screen geometry
    ////////////////////////////////////////

    localparam int coordWidth = 10;
    localparam int sumWidth = coordWidth + 2;   // room for start + offset + origin + size

    // inclusive visible window of the VGA frame
    localparam int displayH0 = 144;             // also the h origin of every rectangle
    localparam int displayH1 = 784;
    localparam int displayV0 = 35;              // also the v origin
    localparam int displayV1 = 515;

    // scene organisation
    localparam int numSets = 6;
    localparam int numSlots = 4;
    localparam int numRects = numSets * numSlots;

    ////////////////////////////////////////
    // types
    ////////////////////////////////////////

    typedef logic [coordWidth-1:0] coord_t;

    // widened coordinate for sums and compares, never wraps
    typedef logic [sumWidth-1:0] coordSum_t;

    typedef struct packed {
        coord_t hStart;
        coord_t vStart;
        coord_t hOffset;
        coord_t vOffset;
        coord_t width;
        coord_t height;
    } rect_t;

    // index is set * numSlots + slot
    typedef rect_t [numRects-1:0] rectSet_t;

    typedef struct packed {
        coord_t hThick;
        coord_t vThick;
    } border_t;

    // stage 1 region result, onBorder only counts when inDisplay is set
    typedef struct packed {
        logic inDisplay;
        logic onBorder;
    } regionFlags;

    typedef enum logic [2:0] {
        colorBlack   = 3'd0,
        colorRed     = 3'd2,
        colorCyan    = 3'd3,
        colorYellow  = 3'd4,
        colorMagenta = 3'd5,
        colorWhite   = 3'd6
    } pixelColor_t;

    ////////////////////////////////////////
    // scroll colors, [set][slot]
    ////////////////////////////////////////

    localparam pixelColor_t [0:numSets-1][0:numSlots-1] scrollColor = '{
        '{colorWhite, colorWhite, colorWhite, colorWhite},      // set 0 is all white
        '{colorRed, colorCyan, colorYellow, colorMagenta},
        '{colorRed, colorCyan, colorYellow, colorMagenta},
        '{colorRed, colorCyan, colorYellow, colorMagenta},
        '{colorRed, colorCyan, colorYellow, colorMagenta},
        '{colorRed, colorCyan, colorYellow, colorMagenta}
    };

endpackage

// ==== hdl/pixelCompositor.sv ====
`timescale 1ns/1ps

module pixelCompositor import compositorPkg::*;
(
    input  logic        clk,
    input  logic        arstN,
    input  coord_t      hCount,
    input  coord_t      vCount,
    input  border_t     borderThick,
    input  rect_t       player,
    input  pixelColor_t playerColor,
    input  rectSet_t    walls,
    input  rectSet_t    scrolls,
    output pixelColor_t sel
);

    // stage 1 to stage 2
    regionFlags          region;
    logic                playerHit;
    logic [numRects-1:0] wallHits;
    logic [numRects-1:0] scrollHits;

    ////////////////////////////////////////
    // stage 1, geometry
    ////////////////////////////////////////

    screenRegion uRegion
    (
        .clk         (clk),
        .arstN       (arstN),
        .hCount      (hCount),
        .vCount      (vCount),
        .borderThick (borderThick),
        .region      (region)
    );

    rectHitArray #(.count(1)) uPlayerHit
    (
        .clk    (clk),
        .arstN  (arstN),
        .hCount (hCount),
        .vCount (vCount),
        .rects  (player),       // single rectangle
        .hits   (playerHit)
    );

    rectHitArray #(.count(numRects)) uWallHit
    (
        .clk    (clk),
        .arstN  (arstN),
        .hCount (hCount),
        .vCount (vCount),
        .rects  (walls),
        .hits   (wallHits)
    );

    rectHitArray #(.count(numRects)) uScrollHit
    (
        .clk    (clk),
        .arstN  (arstN),
        .hCount (hCount),
        .vCount (vCount),
        .rects  (scrolls),
        .hits   (scrollHits)
    );

    ////////////////////////////////////////
    // stage 2, color select
    ////////////////////////////////////////

    colorPriority uPriority
    (
        .clk         (clk),
        .arstN       (arstN),
        .region      (region),
        .playerHit   (playerHit),
        .wallHits    (wallHits),
        .scrollHits  (scrollHits),
        .playerColor (playerColor),     // static, read straight at stage 2
        .sel         (sel)
    );

endmodule

// ==== hdl/rectHitArray.sv ====
`timescale 1ns/1ps

module rectHitArray import compositorPkg::*;
#(
    parameter int count = numRects
)
(
    input  logic              clk,
    input  logic              arstN,
    input  coord_t            hCount,
    input  coord_t            vCount,
    input  rect_t [count-1:0] rects,
    output logic  [count-1:0] hits
);

    logic [count-1:0] hitNext;

    // one axis of the hit rule, both ends inclusive
    function automatic logic spanHit(
        input coord_t    pos,
        input coord_t    start,
        input coord_t    offset,
        input coord_t    size,
        input coordSum_t origin
    );
        coordSum_t lo;
        coordSum_t hi;
        lo = coordSum_t'(start) + coordSum_t'(offset) + origin;
        hi = lo + coordSum_t'(size);
        return (coordSum_t'(pos) >= lo) && (coordSum_t'(pos) <= hi);
    endfunction

    // all rectangles in parallel, no priority here
    always_comb
    begin
        for (int i = 0; i < count; i++)
        begin
            hitNext[i] = spanHit(hCount, rects[i].hStart, rects[i].hOffset,
                                 rects[i].width, coordSum_t'(displayH0))
                      && spanHit(vCount, rects[i].vStart, rects[i].vOffset,
                                 rects[i].height, coordSum_t'(displayV0));
        end
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            hits <= '0;
        end
        else
        begin
            hits <= hitNext;    // stage 1 register
        end
    end

endmodule

// ==== hdl/screenRegion.sv ====
`timescale 1ns/1ps

module screenRegion import compositorPkg::*;
(
    input  logic       clk,
    input  logic       arstN,
    input  coord_t     hCount,
    input  coord_t     vCount,
    input  border_t    borderThick,
    output regionFlags region
);

    coordSum_t hWide;
    coordSum_t vWide;
    coordSum_t hThick;
    coordSum_t vThick;
    logic inWindow;
    logic nearLeft;
    logic nearRight;
    logic nearTop;
    logic nearBottom;

    assign hWide = coordSum_t'(hCount);
    assign vWide = coordSum_t'(vCount);
    assign hThick = coordSum_t'(borderThick.hThick);
    assign vThick = coordSum_t'(borderThick.vThick);

    // visible area, edges included
    assign inWindow = (hWide >= coordSum_t'(displayH0)) && (hWide <= coordSum_t'(displayH1))
                   && (vWide >= coordSum_t'(displayV0)) && (vWide <= coordSum_t'(displayV1));

    ////////////////////////////////////////
    // border frame, inclusive on the inner edge
    ////////////////////////////////////////

    assign nearLeft = hWide <= coordSum_t'(displayH0) + hThick;
    assign nearRight = hWide + hThick >= coordSum_t'(displayH1);    // no underflow this way
    assign nearTop = vWide <= coordSum_t'(displayV0) + vThick;
    assign nearBottom = vWide + vThick >= coordSum_t'(displayV1);

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            region <= '0;
        end
        else
        begin
            region.inDisplay <= inWindow;
            // outside the window this flag is don't care
            region.onBorder <= nearLeft | nearRight | nearTop | nearBottom;
        end
    end

endmodule

// ==== pixelCompositor.f ====
+incdir+verification
hdl/compositorPkg.sv
hdl/screenRegion.sv
hdl/rectHitArray.sv
hdl/colorPriority.sv
hdl/pixelCompositor.sv
verification/pixelCompositorTb.sv

// ==== runSim.sh ====
#!/bin/sh
# Build and run the pixel compositor testbench with Verilator.
# Exit status is 0 only when the run log holds no failure report.

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log
topModule=pixelCompositorTb

if ! command -v verilator >/dev/null 2>&1; then
    echo "runSim: verilator not found in PATH"
    exit 1
fi

verilator --binary --timing -j 0 \
    --top-module "$topModule" \
    -f pixelCompositor.f \
    --Mdir "$buildDir" \
    -o simv
buildStatus=$?
if [ "$buildStatus" -ne 0 ]; then
    echo "runSim: compile failed with status $buildStatus"
    exit 1
fi

"./$buildDir/simv" > "$logFile" 2>&1
runStatus=$?
cat "$logFile"

if grep -q "SIMULATION FAILED" "$logFile"; then
    echo "runSim: failure reported, see $logFile"
    exit 1
fi

if [ "$runStatus" -ne 0 ]; then
    echo "runSim: simulator exited with status $runStatus"
    exit 1
fi

echo "runSim: done"
exit 0

// ==== verification/compositorTests.svh ====
////////////////////////////////////////
// scene helpers
////////////////////////////////////////

function automatic rect_t makeRect(int hStart, int vStart, int hOffset, int vOffset,
                                   int width, int height);
    rect_t r;
    r.hStart = coord_t'(hStart);
    r.vStart = coord_t'(vStart);
    r.hOffset = coord_t'(hOffset);
    r.vOffset = coord_t'(vOffset);
    r.width = coord_t'(width);
    r.height = coord_t'(height);
    return r;
endfunction

// origin beyond any 10-bit beam position
function automatic rect_t parkedRect();
    return makeRect(1000, 1000, 0, 0, 0, 0);
endfunction

function automatic rect_t randomRect();
    return makeRect(randBelow(512), randBelow(384), randBelow(64), randBelow(64),
                    1 + randBelow(128), 1 + randBelow(96));
endfunction

function automatic pixelColor_t randomColor();
    case (randBelow(6))
        0: return colorBlack;
        1: return colorRed;
        2: return colorCyan;
        3: return colorYellow;
        4: return colorMagenta;
        default: return colorWhite;
    endcase
endfunction

task automatic clearScene();
    nextBorder = '0;
    nextPlayer = parkedRect();
    nextPlayerColor = colorBlack;
    for (int i = 0; i < numRects; i++)
    begin
        nextWalls[i] = parkedRect();
        nextScrolls[i] = parkedRect();
    end
endtask

task automatic commitScene();
    @(posedge clk);
    borderThick <= nextBorder;
    player <= nextPlayer;
    playerColor <= nextPlayerColor;
    walls <= nextWalls;
    scrolls <= nextScrolls;
    repeat (3) @(posedge clk);     // settle before any beam is driven
endtask

// one beam position, result read two edges later
task automatic probePixel(int h, int v, pixelColor_t expected, string what);
    @(posedge clk);
    hCount <= coord_t'(h);
    vCount <= coord_t'(v);
    repeat (2) @(posedge clk);
    @(negedge clk);
    checkColor(expected, sel, $sformatf("%s at (%0d,%0d)", what, h, v));
endtask

////////////////////////////////////////
// directed tests
////////////////////////////////////////

task automatic blankingTest();
    clearScene();
    nextWalls[0] = makeRect(0, 0, 0, 0, 879, 988);    // reaches past right and bottom
    commitScene();
    probePixel(displayH0 - 1, 300, colorBlack, "left blank");
    probePixel(displayH1 + 1, 300, colorBlack, "right blank over wall");
    probePixel(400, displayV0 - 1, colorBlack, "top blank");
    probePixel(400, displayV1 + 1, colorBlack, "bottom blank over wall");
    probePixel(400, 300, colorWhite, "wall inside window");
endtask

task automatic borderTest();
    clearScene();
    nextBorder.hThick = coord_t'(5);
    nextBorder.vThick = coord_t'(5);
    commitScene();
    probePixel(displayH0 + 5, 300, colorWhite, "left border inner edge");
    probePixel(displayH0 + 6, 300, colorBlack, "inside left border");
    probePixel(400, displayV1 - 5, colorWhite, "bottom border inner edge");
    probePixel(400, displayV1 - 6, colorBlack, "inside bottom border");
    probePixel(displayH1 - 5, 300, colorWhite, "right border");
    probePixel(400, displayV0 + 5, colorWhite, "top border");
endtask

task automatic playerTest();
    clearScene();
    nextPlayer = makeRect(100, 50, 20, 10, 40, 30);   // h 264..304, v 95..125
    nextPlayerColor = colorMagenta;
    nextWalls[3] = makeRect(146, 80, 0, 0, 40, 25);
    nextScrolls[9] = makeRect(151, 83, 0, 0, 25, 12);
    commitScene();
    probePixel(298, 120, colorMagenta, "player over wall and scroll");
    probePixel(264, 100, colorMagenta, "player left edge");
    probePixel(263, 100, colorBlack, "left of player");
    probePixel(304, 100, colorMagenta, "player right edge");
    probePixel(305, 100, colorBlack, "right of player");
    probePixel(270, 95, colorMagenta, "player top edge");
    probePixel(270, 94, colorBlack, "above player");
    probePixel(270, 125, colorMagenta, "player bottom edge");
    probePixel(270, 126, colorBlack, "below player");
    probePixel(320, 135, colorWhite, "wall outside player");
endtask

task automatic wallTest();
    int idx;
    for (int set = 0; set < numSets; set++)
    begin
        clearScene();
        idx = set * numSlots + set % numSlots;
        nextWalls[idx] = makeRect(200 + set * 40, 150, 5, 5, 20, 20);
        commitScene();
        probePixel(359 + set * 40, 200, colorWhite, $sformatf("wall %0d", idx));
        probePixel(370 + set * 40, 200, colorBlack, $sformatf("right of wall %0d", idx));
    end
    clearScene();
    nextWalls[5] = makeRect(300, 200, 0, 0, 30, 30);
    nextScrolls[12] = makeRect(320, 210, 0, 0, 40, 40);
    commitScene();
    probePixel(470, 250, colorWhite, "wall over scroll");
    probePixel(490, 280, scrollColorOf(12), "scroll beside wall");
endtask

// low index rect placed after high, overlap must still pick low
task automatic scrollOverlap(int low, int high);
    clearScene();
    nextScrolls[high] = makeRect(250, 200, 0, 0, 30, 30);
    nextScrolls[low] = makeRect(260, 210, 0, 0, 30, 30);
    commitScene();
    probePixel(410, 250, scrollColorOf(low), $sformatf("scroll %0d over %0d", low, high));
    probePixel(398, 240, scrollColorOf(high), $sformatf("scroll %0d alone", high));
endtask

task automatic scrollTest();
    for (int idx = 0; idx < numRects; idx++)
    begin
        clearScene();
        nextScrolls[idx] = makeRect(250, 200, 10, 10, 15, 15);
        commitScene();
        probePixel(410, 250, scrollColorOf(idx), $sformatf("scroll slot %0d", idx));
    end
    scrollOverlap(4, 5);
    scrollOverlap(6, 17);
    scrollOverlap(19, 21);
endtask

// new beam every cycle, two results in flight
task automatic randomSceneTest();
    pixelColor_t expected[$];
    int h;
    int v;
    for (int scene = 0; scene < numRandomScenes; scene++)
    begin
        clearScene();
        nextBorder.hThick = coord_t'(randBelow(16));
        nextBorder.vThick = coord_t'(randBelow(16));
        nextPlayer = randomRect();
        nextPlayerColor = randomColor();
        for (int i = 0; i < numRects; i++)
        begin
            if (randBelow(4) == 0)
                nextWalls[i] = randomRect();
            if (randBelow(2) == 0)
                nextScrolls[i] = randomRect();
        end
        commitScene();
        expected.delete();
        for (int step = 0; step < burstLength + 2; step++)
        begin
            @(posedge clk);
            if (step < burstLength)
            begin
                h = 130 + randBelow(670);       // spans both blanking edges
                v = 25 + randBelow(510);
                hCount <= coord_t'(h);
                vCount <= coord_t'(v);
                expected.push_back(refColor(h, v));
            end
            @(negedge clk);
            if (step >= 2)
                checkColor(expected.pop_front(), sel,
                           $sformatf("random scene %0d pixel %0d", scene, step - 2));
        end
    end
endtask

// ==== verification/pixelCompositorTb.sv ====
`timescale 1ns/1ps

module pixelCompositorTb
    import compositorPkg::*;
();

    localparam int clkPeriodNs = 4;
    localparam int numRandomScenes = 8;
    localparam int burstLength = 16;
    localparam int directedPixels = 67;     // reset, blanking, border, player, walls, scroll
    localparam int numTestPixels = directedPixels + numRandomScenes * burstLength;
    localparam int marginNs = 1000;
    localparam int watchdogNs = numTestPixels * 4 * clkPeriodNs + marginNs;

    logic        clk = 1'b0;
    logic        arstN;
    coord_t      hCount;
    coord_t      vCount;
    border_t     borderThick;
    rect_t       player;
    pixelColor_t playerColor;
    rectSet_t    walls;
    rectSet_t    scrolls;
    pixelColor_t sel;

    // scene being built, copied onto the DUT inputs by commitScene
    border_t     nextBorder;
    rect_t       nextPlayer;
    pixelColor_t nextPlayerColor;
    rectSet_t    nextWalls;
    rectSet_t    nextScrolls;

    logic [31:0] lcgState = 32'h600e7fa1;
    int          checkCount = 0;

    always #(clkPeriodNs / 2) clk = ~clk;

    pixelCompositor DUT
    (
        .clk         (clk),
        .arstN       (arstN),
        .hCount      (hCount),
        .vCount      (vCount),
        .borderThick (borderThick),
        .player      (player),
        .playerColor (playerColor),
        .walls       (walls),
        .scrolls     (scrolls),
        .sel         (sel)
    );

    ////////////////////////////////////////
    // random numbers
    ////////////////////////////////////////

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic int randBelow(int n);
        return int'((nextRandom() >> 8) % n);     // low bits of an LCG are weak
    endfunction

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    function automatic bit rectCovers(rect_t r, int h, int v);
        int hLo;
        int vLo;
        hLo = int'(r.hStart) + int'(r.hOffset) + displayH0;
        vLo = int'(r.vStart) + int'(r.vOffset) + displayV0;
        return (h >= hLo) && (h <= hLo + int'(r.width))
            && (v >= vLo) && (v <= vLo + int'(r.height));
    endfunction

    // set 0 white, other sets red, cyan, yellow, magenta by slot
    function automatic pixelColor_t scrollColorOf(int idx);
        if (idx / numSlots == 0)
            return colorWhite;
        case (idx % numSlots)
            0: return colorRed;
            1: return colorCyan;
            2: return colorYellow;
            default: return colorMagenta;
        endcase
    endfunction

    function automatic pixelColor_t refColor(int h, int v);
        int hThick;
        int vThick;
        hThick = int'(borderThick.hThick);
        vThick = int'(borderThick.vThick);
        if (h < displayH0 || h > displayH1 || v < displayV0 || v > displayV1)
            return colorBlack;
        if (h <= displayH0 + hThick || h >= displayH1 - hThick
                || v <= displayV0 + vThick || v >= displayV1 - vThick)
            return colorWhite;
        if (rectCovers(player, h, v))
            return playerColor;
        for (int i = 0; i < numRects; i++)
            if (rectCovers(walls[i], h, v))
                return colorWhite;
        for (int i = 0; i < numRects; i++)     // lowest index first
            if (rectCovers(scrolls[i], h, v))
                return scrollColorOf(i);
        return colorBlack;
    endfunction

    task automatic checkColor(pixelColor_t expected, pixelColor_t actual, string what);
        checkCount++;
        if (actual !== expected)
        begin
            $display("** Error at %0t: %s, expected %s (%0d) got %s (%0d)", $time, what,
                     expected.name(), expected, actual.name(), actual);
            $display("SIMULATION FAILED");
            $fatal(1, "pixel color mismatch");
        end
    endtask

    `include "compositorTests.svh"

    initial
    begin
        #(watchdogNs);
        $display("watchdog: run did not finish within %0d ns", watchdogNs);
        $display("SIMULATION FAILED");
        $fatal(1, "timeout");
    end

    initial
    begin
        arstN = 1'b0;
        hCount = coord_t'(displayH0);       // frame corner, white once reset lets go
        vCount = coord_t'(displayV0);
        clearScene();
        borderThick = nextBorder;
        player = nextPlayer;
        playerColor = nextPlayerColor;
        walls = nextWalls;
        scrolls = nextScrolls;

        repeat (2) @(posedge clk);
        @(negedge clk);
        checkColor(colorBlack, sel, "sel during reset");
        repeat (2) @(posedge clk);
        arstN <= 1'b1;      // 4 cycles low
        @(negedge clk);
        checkColor(colorBlack, sel, "sel right after reset");

        blankingTest();
        borderTest();
        playerTest();
        wallTest();
        scrollTest();
        randomSceneTest();

        if (checkCount == directedPixels + numRandomScenes * burstLength)
        begin
            $display("SIMULATION PASSED");
            $finish;
        end
        else
        begin
            $display("only %0d of the planned checks ran", checkCount);
            $display("SIMULATION FAILED");
            $fatal(1, "check count");
        end
    end

endmodule
